// ==== design/alu_isa_pkg.sv ====
// alu isa package with the word width, divider step count and operation codes
package alu_isa_pkg;

    localparam int word_width = 32;

    // one quotient bit per divider cycle
    localparam int div_steps = 32;
    localparam int div_cnt_width = $clog2(div_steps);

    typedef logic [word_width-1:0] word_t;

    typedef enum logic [4:0] {
        OP_ADDU,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLT,
        OP_SLTU,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_MULT,
        OP_MULTU,
        OP_DIV,
        OP_DIVU,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO
    } alu_op_e;

endpackage

// ==== design/alu_link_pkg.sv ====
// alu link package with the structs passed between the sides of the unit
package alu_link_pkg;

    // host command, held stable for the whole transaction
    typedef struct packed {
        alu_isa_pkg::alu_op_e op;
        alu_isa_pkg::word_t   src_a;
        alu_isa_pkg::word_t   src_b;
    } alu_cmd_t;

    // done is a single-cycle pulse
    typedef struct packed {
        logic               done;
        alu_isa_pkg::word_t result;
    } alu_resp_t;

    typedef struct packed {
        alu_isa_pkg::word_t dividend;
        alu_isa_pkg::word_t divisor;
        logic               is_signed;
    } div_req_t;

endpackage

// ==== design/req_port.sv ====
// request port, accepts a four-phase request and issues one start to the core
module req_port (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_i,
    input  alu_link_pkg::alu_cmd_t cmd_i,
    input  logic                   release_i,
    output logic                   start_o,
    output alu_link_pkg::alu_cmd_t cmd_o
);

    logic idle_q;
    logic accept;

    // a held request is taken only once per transaction
    assign accept = req_i && idle_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            idle_q  <= 1'b1;
            start_o <= 1'b0;
        end else begin
            start_o <= 1'b0;
            if (accept) begin
                start_o <= 1'b1;
                idle_q  <= 1'b0;
            end else if (release_i) begin
                // response side finished the handshake
                idle_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_o <= cmd_i;
        end
    end

endmodule

// ==== design/div_iter.sv ====
// div iter, radix-2 restoring divider with signed and unsigned operands
module div_iter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_i,
    input  alu_link_pkg::div_req_t req_i,
    output logic                   done_o,
    output alu_isa_pkg::word_t     quotient_o,
    output alu_isa_pkg::word_t     remainder_o
);

    import alu_isa_pkg::*;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_ZERO,
        DIV_RUN,
        DIV_FIX
    } div_state_e;

    div_state_e               state_q;
    logic [div_cnt_width-1:0] step_q;

    word_t rem_q;
    word_t quot_q;
    word_t dvsr_q;
    logic  neg_quot_q;
    logic  neg_rem_q;

    logic          dividend_neg;
    logic          divisor_neg;
    word_t         dividend_mag;
    word_t         divisor_mag;
    logic [word_width:0] shifted;
    logic [word_width:0] diff;

    assign dividend_neg = req_i.is_signed && req_i.dividend[word_width-1];
    assign divisor_neg  = req_i.is_signed && req_i.divisor[word_width-1];
    assign dividend_mag = dividend_neg ? -req_i.dividend : req_i.dividend;
    assign divisor_mag  = divisor_neg ? -req_i.divisor : req_i.divisor;

    // one trial subtract per cycle
    assign shifted = {rem_q, quot_q[word_width-1]};
    assign diff    = shifted - {1'b0, dvsr_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= DIV_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    step_q <= '0;
                    if (start_i) begin
                        state_q <= (req_i.divisor == '0) ? DIV_ZERO : DIV_RUN;
                    end
                end
                DIV_RUN: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == div_cnt_width'(div_steps - 1)) begin
                        state_q <= DIV_FIX;
                    end
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == DIV_IDLE && start_i) begin
            dvsr_q <= divisor_mag;
            if (req_i.divisor == '0) begin
                // defined result for a zero divisor
                quot_q     <= '1;
                rem_q      <= req_i.dividend;
                neg_quot_q <= 1'b0;
                neg_rem_q  <= 1'b0;
            end else begin
                quot_q     <= dividend_mag;
                rem_q      <= '0;
                neg_quot_q <= dividend_neg ^ divisor_neg;
                neg_rem_q  <= dividend_neg;
            end
        end else if (state_q == DIV_RUN) begin
            if (!diff[word_width]) begin
                rem_q  <= diff[word_width-1:0];
                quot_q <= {quot_q[word_width-2:0], 1'b1};
            end else begin
                rem_q  <= shifted[word_width-1:0];
                quot_q <= {quot_q[word_width-2:0], 1'b0};
            end
        end
    end

    // sign fix on the way out, remainder follows the dividend
    assign done_o      = (state_q == DIV_ZERO) || (state_q == DIV_FIX);
    assign quotient_o  = neg_quot_q ? -quot_q : quot_q;
    assign remainder_o = neg_rem_q ? -rem_q : rem_q;

endmodule

// ==== design/exec_core.sv ====
// exec core, integer alu, multiplier and hi/lo pair with a multi-cycle divider
module exec_core (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start_i,
    input  alu_link_pkg::alu_cmd_t  cmd_i,
    output alu_link_pkg::alu_resp_t resp_o
);

    import alu_isa_pkg::*;
    import alu_link_pkg::*;

    word_t hi_q;
    word_t lo_q;
    logic  done_q;
    word_t result_q;

    logic     is_div;
    logic     mul_signed;
    logic [4:0] shamt;
    logic [2*word_width-1:0] mul_a;
    logic [2*word_width-1:0] mul_b;
    logic [2*word_width-1:0] product;

    word_t alu_res;
    word_t hi_d;
    word_t lo_d;
    logic  hi_we;
    logic  lo_we;

    logic     div_start;
    div_req_t div_req;
    logic     div_done;
    word_t    div_quot;
    word_t    div_rem;

    assign is_div     = (cmd_i.op == OP_DIV) || (cmd_i.op == OP_DIVU);
    assign mul_signed = (cmd_i.op == OP_MULT);
    assign shamt      = cmd_i.src_b[4:0];

    // sign-extend for mult, low 64 bits are then right for both kinds
    assign mul_a   = {{word_width{mul_signed && cmd_i.src_a[word_width-1]}}, cmd_i.src_a};
    assign mul_b   = {{word_width{mul_signed && cmd_i.src_b[word_width-1]}}, cmd_i.src_b};
    assign product = mul_a * mul_b;

    always_comb begin
        alu_res = '0;
        hi_d    = hi_q;
        lo_d    = lo_q;
        hi_we   = 1'b0;
        lo_we   = 1'b0;
        case (cmd_i.op)
            OP_ADDU: alu_res = cmd_i.src_a + cmd_i.src_b;
            OP_SUBU: alu_res = cmd_i.src_a - cmd_i.src_b;
            OP_AND:  alu_res = cmd_i.src_a & cmd_i.src_b;
            OP_OR:   alu_res = cmd_i.src_a | cmd_i.src_b;
            OP_XOR:  alu_res = cmd_i.src_a ^ cmd_i.src_b;
            OP_NOR:  alu_res = ~(cmd_i.src_a | cmd_i.src_b);
            OP_SLT:  alu_res = word_t'($signed(cmd_i.src_a) < $signed(cmd_i.src_b));
            OP_SLTU: alu_res = word_t'(cmd_i.src_a < cmd_i.src_b);
            OP_SLL:  alu_res = cmd_i.src_a << shamt;
            OP_SRL:  alu_res = cmd_i.src_a >> shamt;
            OP_SRA:  alu_res = word_t'($signed(cmd_i.src_a) >>> shamt);
            OP_MULT, OP_MULTU: begin
                hi_we   = 1'b1;
                lo_we   = 1'b1;
                hi_d    = product[2*word_width-1:word_width];
                lo_d    = product[word_width-1:0];
                alu_res = product[word_width-1:0];
            end
            OP_MFHI: alu_res = hi_q;
            OP_MFLO: alu_res = lo_q;
            OP_MTHI: begin
                hi_we   = 1'b1;
                hi_d    = cmd_i.src_a;
                alu_res = lo_q;
            end
            OP_MTLO: begin
                lo_we   = 1'b1;
                lo_d    = cmd_i.src_a;
                alu_res = cmd_i.src_a;
            end
            default: alu_res = '0;
        endcase
    end

    // divides go to the divider instead of finishing next cycle
    assign div_start = start_i && is_div;
    assign div_req   = '{dividend: cmd_i.src_a, divisor: cmd_i.src_b,
                         is_signed: (cmd_i.op == OP_DIV)};

    div_iter u_div_iter (
        .clk         (clk),
        .rst         (rst),
        .start_i     (div_start),
        .req_i       (div_req),
        .done_o      (div_done),
        .quotient_o  (div_quot),
        .remainder_o (div_rem)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            hi_q   <= '0;
            lo_q   <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start_i && !is_div) begin
                done_q <= 1'b1;
                if (hi_we) begin
                    hi_q <= hi_d;
                end
                if (lo_we) begin
                    lo_q <= lo_d;
                end
            end else if (div_done) begin
                done_q <= 1'b1;
                hi_q   <= div_rem;
                lo_q   <= div_quot;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i && !is_div) begin
            result_q <= alu_res;
        end else if (div_done) begin
            result_q <= div_quot;
        end
    end

    assign resp_o = '{done: done_q, result: result_q};

endmodule

// ==== design/resp_port.sv ====
// response port, holds the result and completes the four-phase handshake
module resp_port (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_i,
    input  alu_link_pkg::alu_resp_t resp_i,
    output logic                    ack_o,
    output alu_isa_pkg::word_t      result_o,
    output logic                    release_o
);

    logic drop_ack;

    // host has let go of the request
    assign drop_ack = ack_o && !req_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_o     <= 1'b0;
            release_o <= 1'b0;
        end else begin
            release_o <= 1'b0;
            if (resp_i.done) begin
                ack_o <= 1'b1;
            end else if (drop_ack) begin
                ack_o     <= 1'b0;
                release_o <= 1'b1;
            end
        end
    end

    // result stays put while ack is high
    always_ff @(posedge clk) begin
        if (resp_i.done) begin
            result_o <= resp_i.result;
        end
    end

endmodule

// ==== design/alu_unit_top.sv ====
// alu unit top, request port, execute core and response port behind req/ack
module alu_unit_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_i,
    input  alu_link_pkg::alu_cmd_t cmd_i,
    output logic                   ack_o,
    output alu_isa_pkg::word_t     result_o
);

    import alu_link_pkg::*;

    logic      core_start;
    alu_cmd_t  core_cmd;
    alu_resp_t core_resp;
    logic      release_pulse;

    req_port u_req_port (
        .clk       (clk),
        .rst       (rst),
        .req_i     (req_i),
        .cmd_i     (cmd_i),
        .release_i (release_pulse),
        .start_o   (core_start),
        .cmd_o     (core_cmd)
    );

    exec_core u_exec_core (
        .clk     (clk),
        .rst     (rst),
        .start_i (core_start),
        .cmd_i   (core_cmd),
        .resp_o  (core_resp)
    );

    resp_port u_resp_port (
        .clk       (clk),
        .rst       (rst),
        .req_i     (req_i),
        .resp_i    (core_resp),
        .ack_o     (ack_o),
        .result_o  (result_o),
        .release_o (release_pulse)
    );

endmodule

// ==== bench/tb_alu_unit.sv ====
// testbench for the alu unit, random four-phase traffic checked against a reference model
module tb_alu_unit;

    import alu_isa_pkg::*;
    import alu_link_pkg::*;

    // 50 cycles covers a divide plus the longest back-pressure hold
    localparam int max_txns       = 400;
    localparam int cycles_per_txn = 50;
    localparam int cycle_limit    = max_txns * cycles_per_txn;

    logic     clk;
    logic     rst;
    logic     req_i;
    alu_cmd_t cmd_i;
    logic     ack_o;
    word_t    result_o;

    // model copies of hi and lo
    word_t model_hi = '0;
    word_t model_lo = '0;

    word_t expect_q[$];
    int    txn_count    = 0;
    int    results_seen = 0;

    alu_unit_top dut_i (
        .clk      (clk),
        .rst      (rst),
        .req_i    (req_i),
        .cmd_i    (cmd_i),
        .ack_o    (ack_o),
        .result_o (result_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("MISMATCH at time %0t: %s is %h, expected %h", $time, name, got, expected);
            $display("FAIL: see errors above");
            $fatal(1, "stopping on first error");
        end
    endtask

    // expected result_o, hi/lo written by the same rules the unit follows
    function automatic word_t ref_exec(input alu_op_e op, input word_t a, input word_t b);
        word_t       res;
        longint      sa;
        longint      sb;
        longint      q;
        longint      r;
        logic [63:0] prod;
        res = '0;
        case (op)
            OP_ADDU: res = a + b;
            OP_SUBU: res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_NOR:  res = ~(a | b);
            OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            OP_SLL:  res = a << b[4:0];
            OP_SRL:  res = a >> b[4:0];
            OP_SRA:  res = $signed(a) >>> b[4:0];
            OP_MULT: begin
                sa       = longint'($signed(a));
                sb       = longint'($signed(b));
                prod     = 64'(sa * sb);
                model_hi = prod[63:32];
                model_lo = prod[31:0];
                res      = model_lo;
            end
            OP_MULTU: begin
                prod     = {32'b0, a} * {32'b0, b};
                model_hi = prod[63:32];
                model_lo = prod[31:0];
                res      = model_lo;
            end
            OP_DIV, OP_DIVU: begin
                if (b == '0) begin
                    model_lo = '1;
                    model_hi = a;
                end else begin
                    // 64-bit signed math truncates toward zero without overflow
                    if (op == OP_DIV) begin
                        sa = longint'($signed(a));
                        sb = longint'($signed(b));
                    end else begin
                        sa = longint'({32'b0, a});
                        sb = longint'({32'b0, b});
                    end
                    q        = sa / sb;
                    r        = sa % sb;
                    model_lo = word_t'(q);
                    model_hi = word_t'(r);
                end
                res = model_lo;
            end
            OP_MFHI: res = model_hi;
            OP_MFLO: res = model_lo;
            OP_MTHI: begin
                model_hi = a;
                res      = model_lo;
            end
            OP_MTLO: begin
                model_lo = a;
                res      = a;
            end
            default: res = '0;
        endcase
        return res;
    endfunction

    function automatic word_t pick_operand();
        case ($urandom_range(5, 0))
            0: return 32'h8000_0000;
            1: return 32'h7fff_ffff;
            2: return 32'hffff_ffff;
            3: return 32'h0000_0001;
            default: return $urandom();
        endcase
    endfunction

    function automatic word_t pick_divisor();
        case ($urandom_range(5, 0))
            0: return '0;
            1: return $urandom() | 32'h8000_0000;
            2: return word_t'($urandom_range(15, 1));
            3: return 32'hffff_ffff;
            default: return $urandom();
        endcase
    endfunction

    // one full four-phase transaction, req held for hold extra cycles after ack
    task automatic do_transaction(input alu_op_e op, input word_t a, input word_t b,
                                  input int hold);
        expect_q.push_back(ref_exec(op, a, b));
        txn_count++;
        @(posedge clk);
        cmd_i <= '{op: op, src_a: a, src_b: b};
        req_i <= 1'b1;
        @(posedge clk);
        while (!ack_o) @(posedge clk);
        repeat (hold) begin
            @(posedge clk);
            check_value("ack_o", word_t'(ack_o), word_t'(1));
        end
        req_i <= 1'b0;
        @(posedge clk);
        while (ack_o) @(posedge clk);
    endtask

    task automatic send_op(input alu_op_e op, input word_t a, input word_t b);
        do_transaction(op, a, b, int'($urandom_range(3, 0)));
    endtask

    initial begin : stimulus
        alu_op_e op;
        word_t   a;
        word_t   b;
        int      i;
        void'($urandom(32'h8015_f344));
        rst   = 1'b1;
        req_i = 1'b0;
        cmd_i = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("ack_o", word_t'(ack_o), '0);

        // hi and lo come out of reset as zero
        send_op(OP_MFHI, '0, '0);
        send_op(OP_MFLO, '0, '0);

        for (i = 0; i < 150; i++) begin
            op = alu_op_e'(5'($urandom_range(10, 0)));
            a  = $urandom();
            b  = ($urandom_range(3, 0) == 0) ? word_t'($urandom_range(63, 0)) : $urandom();
            send_op(op, a, b);
        end
        send_op(OP_SLL, 32'h1234_5678, 32'd35);
        send_op(OP_SRL, 32'hf0f0_0f0f, 32'hffff_ffe1);
        send_op(OP_SRA, 32'h8000_0000, 32'd63);

        for (i = 0; i < 30; i++) begin
            op = ($urandom_range(1, 0) == 0) ? OP_MULT : OP_MULTU;
            send_op(op, pick_operand(), pick_operand());
            send_op(OP_MFHI, '0, '0);
        end

        for (i = 0; i < 30; i++) begin
            op = ($urandom_range(1, 0) == 0) ? OP_DIV : OP_DIVU;
            send_op(op, pick_operand(), pick_divisor());
            send_op(OP_MFHI, '0, '0);
        end
        send_op(OP_DIV, 32'h8000_0000, 32'hffff_ffff);
        send_op(OP_MFHI, '0, '0);
        send_op(OP_DIV, 32'hffff_fff9, 32'd2);
        send_op(OP_MFHI, '0, '0);
        send_op(OP_DIV, 32'd7, 32'hffff_fffe);
        send_op(OP_MFHI, '0, '0);
        send_op(OP_DIVU, 32'hffff_ffff, '0);
        send_op(OP_MFHI, '0, '0);
        send_op(OP_DIV, 32'hffff_fffb, '0);
        send_op(OP_MFHI, '0, '0);

        // long holds on ack
        for (i = 0; i < 12; i++) begin
            op = alu_op_e'(5'($urandom_range(18, 0)));
            do_transaction(op, pick_operand(), pick_divisor(), int'($urandom_range(12, 4)));
        end

        for (i = 0; i < 5; i++) begin
            a = $urandom();
            b = $urandom();
            send_op(OP_MTHI, a, '0);
            send_op(OP_MTLO, b, '0);
            send_op(OP_MFHI, '0, '0);
            send_op(OP_MFLO, '0, '0);
            send_op(OP_MULTU, pick_operand(), pick_operand());
            send_op(OP_MFHI, '0, '0);
            send_op(OP_MTLO, $urandom(), '0);
            send_op(OP_DIV, pick_operand(), pick_divisor());
            send_op(OP_MFHI, '0, '0);
            send_op(OP_MFLO, '0, '0);
        end

        repeat (2) @(posedge clk);
        if (results_seen != txn_count || expect_q.size() != 0) begin
            $display("unit gave %0d results for %0d transactions", results_seen, txn_count);
            $display("FAIL: see errors above");
            $fatal(1, "result count wrong at end of run");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

    // sampled on the falling edge, away from the drive edge
    initial begin : compare_results
        logic  ack_prev;
        word_t held;
        ack_prev = 1'b0;
        held     = '0;
        forever begin
            @(negedge clk);
            if (ack_o && !ack_prev) begin
                if (expect_q.size() == 0) begin
                    $display("ack_o rose at time %0t with no request outstanding", $time);
                    $display("FAIL: see errors above");
                    $fatal(1, "extra result from the unit");
                end else begin
                    check_value("result_o", result_o, expect_q.pop_front());
                    held = result_o;
                    results_seen++;
                end
            end else if (ack_o) begin
                // must not move while the host holds req
                check_value("result_o", result_o, held);
            end
            ack_prev = ack_o;
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= cycle_limit) begin
                $display("timeout after %0d cycles, the unit stopped answering", cycles);
                $display("FAIL: see errors above");
                $fatal(1, "timeout");
            end
        end
    end

endmodule

// ==== compile.f ====
design/alu_isa_pkg.sv
design/alu_link_pkg.sv
design/req_port.sv
design/div_iter.sv
design/exec_core.sv
design/resp_port.sv
design/alu_unit_top.sv
bench/tb_alu_unit.sv

// ==== Makefile ====
SIM       = verilator
SIM_FLAGS = --binary --timing -j 0
TOP       = tb_alu_unit
FILE_LIST = compile.f
LOG       = sim.log
BIN       = obj_dir/V$(TOP)
FAIL_MSG  = FAIL: see errors above
PASS_MSG  = PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP) and check $(LOG)"
	@echo "  clean  remove build output and $(LOG)"
	@echo "  help   list these targets"

$(BIN): $(FILE_LIST) $(shell cat $(FILE_LIST))
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

test: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
